//--- flist.f
verilog/sdram_proto_pkg.sv
verilog/ctrl_state_pkg.sv
verilog/sdram_ifs.sv
verilog/sdram_timers.sv
verilog/sdram_sequencer.sv
verilog/sdram_datapath.sv
verilog/sdram_ctrl.sv
verif/sdram_model.sv
verif/sdram_checker.sv
verif/tb_sdram_ctrl.sv

//--- verif/sdram_checker.sv
`timescale 1ns/1ps

module sdram_checker import sdram_proto_pkg::*; #(
	parameter int REF_CYC = 375                  // Refresh interval in cycles
) (
	input logic                    clk,
	input logic                    n_reset,
	input logic                    rd_n,
	input logic                    wr_n,
	input logic [CPU_ADDR_W-1:0]   address,
	input logic [7:0]              wdata,
	input logic                    busy,
	input logic [15:0]             rdata,
	input logic                    rdata_en,
	input logic                    sdram_cke,
	input logic                    sdram_cs_n,
	input logic                    sdram_ras_n,
	input logic                    sdram_cas_n,
	input logic                    sdram_we_n,
	input logic [SDRAM_ADDR_W-1:0] sdram_addr,
	input logic [SDRAM_BA_W-1:0]   sdram_ba,
	input logic [DQM_W-1:0]        sdram_dqm,
	input logic [15:0]             exp_rdata,    // Table value for reads
	input logic                    exp_known
);
	logic [7:0]            shadow [logic [CPU_ADDR_W-1:0]];
	int                    tests = 0, passes = 0, errors = 0;
	int                    init_step = 0, cyc = 0, last_ref = -1, ref_cnt = 0, idle_mark;
	bit                    init_seen = 0, in_acc = 0, acc_wr, acc_err = 0, pred_ok, exp_k;
	logic [CPU_ADDR_W-1:0] acc_addr, a0;
	logic [15:0]           pred, exp_q;
	int                    act_cnt, col_cnt, pre_cnt, ren_cnt;
	sdram_cmd_t            cmd;

	assign cmd = sdram_cmd_t'({sdram_ras_n, sdram_cas_n, sdram_we_n});

	task automatic value_error(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		errors++;
		acc_err = 1;
	endtask

	task automatic fault(input string msg);
		$display("Problem at %0t ns: %s", $time, msg);
		errors++;
		acc_err = 1;
	endtask

	task automatic idle_start();
		idle_mark = ref_cnt;
	endtask

	// At least one refresh per interval plus slack
	task automatic idle_done(input int cycles);
		tests++;
		if (ref_cnt - idle_mark < cycles / (REF_CYC + 16))
			fault("too few auto refreshes in the idle stretch");
		else
			passes++;
		$display("Test %0d idle %0d cycles, %0d refreshes", tests, cycles, ref_cnt - idle_mark);
	endtask

	always @(posedge clk) begin
		if (n_reset) begin
			cyc++;
			if (sdram_cke !== 1'b1)
				fault("SDRAM clock enable is not high");
			// --------------------
			// Command order on the pins
			if (!sdram_cs_n && cmd != NOP) begin
				if (!init_seen) begin
					case (init_step)
						0: if (cmd != PRECHARGE || !sdram_addr[PRECHARGE_ALL_BIT])
							fault("power-up must start with precharge all");
						1, 2: if (cmd != AUTO_REFRESH)
							fault("power-up needs two auto refreshes after precharge");
						3: if (cmd != LOAD_MODE || sdram_addr !== MODE_REG_CL2_BL1)
							fault("power-up mode register load wrong");
						default: fault("extra command during power-up");
					endcase
					if (cmd == AUTO_REFRESH)
						last_ref = cyc;
					init_step++;
				end else begin
					case (cmd)
						ACTIVE: begin
							if (!in_acc)
								fault("ACTIVE outside an access");
							else if (sdram_ba !== acc_addr[BANK_MSB:BANK_LSB] ||
									sdram_addr !== acc_addr[ROW_MSB:ROW_LSB])
								value_error($sformatf("ACTIVE bank %0d row %h for %h",
									sdram_ba, sdram_addr, acc_addr));
							act_cnt++;
						end
						WRITE, READ: begin
							if (act_cnt != 1 || col_cnt != 0)
								fault("column command without a single ACTIVE before it");
							if ((cmd == WRITE) != acc_wr)
								fault("column command does not match the request");
							if (sdram_ba !== acc_addr[BANK_MSB:BANK_LSB] ||
									sdram_addr !== {3'b000, acc_addr[COL_MSB:COL_LSB]})
								value_error($sformatf("column bank %0d addr %h for %h",
									sdram_ba, sdram_addr, acc_addr));
							// Only the addressed lane unmasked
							if (cmd == WRITE && (sdram_dqm[acc_addr[1:0]] !== 1'b0 ||
									$countones(sdram_dqm) != 3))
								value_error($sformatf("dqm %b for lane %0d", sdram_dqm,
									acc_addr[1:0]));
							if (cmd == READ && sdram_dqm !== 4'b0000)
								value_error($sformatf("dqm %b on a read", sdram_dqm));
							col_cnt++;
						end
						PRECHARGE: begin
							if (col_cnt != 1 || !sdram_addr[PRECHARGE_ALL_BIT])
								fault("precharge all missing or out of order");
							pre_cnt++;
						end
						AUTO_REFRESH: begin
							if (last_ref >= 0 && cyc - last_ref > REF_CYC + 16)
								fault($sformatf("refresh gap of %0d cycles", cyc - last_ref));
							last_ref = cyc;
							ref_cnt++;
						end
						default: fault("unexpected command after power-up");
					endcase
				end
			end
			// --------------------
			// Read data
			if (rdata_en) begin
				ren_cnt++;
				if (!in_acc || acc_wr)
					fault("rdata_en without a read");
				else if (!pred_ok || rdata !== pred)
					value_error($sformatf("read %h got %h, shadow %h", acc_addr, rdata, pred));
				else if (exp_k && rdata !== exp_q)
					value_error($sformatf("read %h got %h, table %h", acc_addr, rdata, exp_q));
			end
			// Power-up end
			if (!init_seen && !busy) begin
				tests++;
				if (init_step != 4)
					fault("busy fell before the power-up sequence finished");
				if (!acc_err)
					passes++;
				$display("Test %0d power-up %s", tests, acc_err ? "FAIL" : "PASS");
				init_seen = 1;
			end
			// Access end
			if (in_acc && !busy) begin
				tests++;
				if (act_cnt != 1 || col_cnt != 1 || pre_cnt != 1)
					fault("access did not run ACTIVE, column, PRECHARGE once each");
				if (ren_cnt != (acc_wr ? 0 : 1))
					fault($sformatf("%0d rdata_en pulses", ren_cnt));
				if (!acc_err)
					passes++;
				$display("Test %0d %s %h %s", tests, acc_wr ? "write" : "read ", acc_addr,
					acc_err ? "FAIL" : "PASS");
				in_acc = 0;
			end
			// Acceptance, same rule as the sequencer
			if (init_seen && !busy && (!wr_n || !rd_n)) begin
				acc_addr = address;
				acc_wr   = !wr_n;
				if (acc_wr)
					shadow[address] = wdata;
				a0      = {address[CPU_ADDR_W-1:1], 1'b0};
				pred_ok = shadow.exists(a0) && shadow.exists(a0 | 1);
				if (pred_ok)
					pred = {shadow[a0 | 1], shadow[a0]};    // Little end first
				exp_q   = exp_rdata;
				exp_k   = exp_known;
				act_cnt = 0;
				col_cnt = 0;
				pre_cnt = 0;
				ren_cnt = 0;
				acc_err = 0;
				in_acc  = 1;
			end
		end
	end
endmodule

//--- verif/sdram_model.sv
`timescale 1ns/1ps

module sdram_model import sdram_proto_pkg::*; (
	input  logic                    clk,
	input  logic                    cke,
	input  logic                    cs_n,
	input  logic                    ras_n,
	input  logic                    cas_n,
	input  logic                    we_n,
	input  logic [SDRAM_ADDR_W-1:0] addr,
	input  logic [SDRAM_BA_W-1:0]   ba,
	input  logic [DQM_W-1:0]        dqm,
	inout  wire  [SDRAM_DQ_W-1:0]   dq
);
	logic [SDRAM_DQ_W-1:0]   mem [logic [20:0]];  // Key is {bank, row, column}
	logic [SDRAM_ADDR_W-1:0] open_row [4];
	logic                    rd_pend;             // READ seen one edge ago
	logic [20:0]             rd_key;
	logic [SDRAM_DQ_W-1:0]   dq_out;
	logic                    dq_oe;

	assign dq = dq_oe ? dq_out : 'z;

	initial begin
		rd_pend = 1'b0;
		dq_oe   = 1'b0;
	end

	// --------------------
	// Command decode, CAS latency 2
	always @(posedge clk) begin
		logic [20:0]           key;
		logic [SDRAM_DQ_W-1:0] word;
		key = {ba, open_row[ba], addr[COL_W-1:0]};
		if (rd_pend) begin
			dq_out <= #1 mem.exists(rd_key) ? mem[rd_key] : 'x;  // Valid over second edge
			dq_oe  <= #1 1'b1;
		end else
			dq_oe  <= #1 1'b0;
		rd_pend <= 1'b0;
		if (cke && !cs_n) begin
			case (sdram_cmd_t'({ras_n, cas_n, we_n}))
				ACTIVE: open_row[ba] = addr;
				READ: begin
					rd_pend <= 1'b1;
					rd_key  <= key;
				end
				WRITE: begin
					word = mem.exists(key) ? mem[key] : '0;
					for (int i = 0; i < DQM_W; i++)
						if (!dqm[i])
							word[i*8 +: 8] = dq[i*8 +: 8];  // Masked lanes kept
					mem[key] = word;
				end
				default: ;
			endcase
		end
	end
endmodule

//--- verif/tb_sdram_ctrl.sv
`timescale 1ns/1ps

module tb_sdram_ctrl import ctrl_state_pkg::*; ();
	localparam int FREQ  = 25_000_000;
	localparam int OP_WR = 0, OP_RD = 1, OP_IDLE = 2;

	logic        clk = 0, n_reset, rd_n, wr_n, busy, rdata_en;
	logic [22:0] address;
	logic [7:0]  wdata;
	logic [15:0] rdata, exp_rdata;
	logic        exp_known;
	logic        sdram_clk, sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
	logic [10:0] sdram_addr;
	logic [1:0]  sdram_ba;
	logic [3:0]  sdram_dqm;
	wire  [31:0] sdram_dq;

	// Stimulus table
	int          t_op [64];
	logic [22:0] t_addr [64];    // Idle entries keep the cycle count here
	logic [7:0]  t_data [64];
	logic [15:0] t_exp [64];
	bit          t_known [64], t_hold [64];
	int          n_ent = 0, seed = 39759, limit = 0, idle_total = 0;
	logic [22:0] ra;
	logic [7:0]  d0, d1;

	always #20 clk = ~clk;    // 25 MHz

	sdram_ctrl #(.FREQ(FREQ)) uut (.*);

	sdram_model mem (
		.clk(sdram_clk), .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n),
		.cas_n(sdram_cas_n), .we_n(sdram_we_n), .addr(sdram_addr), .ba(sdram_ba),
		.dqm(sdram_dqm), .dq(sdram_dq)
	);

	sdram_checker #(.REF_CYC(refresh_cycles(FREQ))) chk (
		.clk, .n_reset, .rd_n, .wr_n, .address, .wdata, .busy, .rdata, .rdata_en,
		.sdram_cke, .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n, .sdram_addr,
		.sdram_ba, .sdram_dqm, .exp_rdata, .exp_known
	);

	task automatic add_entry(input int op, input logic [22:0] a, input logic [7:0] d,
			input logic [15:0] e, input bit k, input bit h);
		t_op[n_ent]    = op;
		t_addr[n_ent]  = a;
		t_data[n_ent]  = d;
		t_exp[n_ent]   = e;
		t_known[n_ent] = k;
		t_hold[n_ent]  = h;
		n_ent++;
	endtask

	task automatic next_slot();    // Just after the rising edge
		@(posedge clk);
		#5;
	endtask

	// --------------------
	// Watchdog
	initial begin
		wait (limit > 0);
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Something failed");
		$finish;
	end

	initial begin
		n_reset   = 0;
		rd_n      = 1;
		wr_n      = 1;
		address   = '0;
		wdata     = '0;
		exp_rdata = '0;
		exp_known = 0;
		// Four lanes of one word, then both halves back
		add_entry(OP_WR, 23'h012344, 8'h11, 16'h0, 0, 0);
		add_entry(OP_WR, 23'h012345, 8'h22, 16'h0, 0, 0);
		add_entry(OP_WR, 23'h012346, 8'h33, 16'h0, 0, 0);
		add_entry(OP_WR, 23'h012347, 8'h44, 16'h0, 0, 0);
		add_entry(OP_RD, 23'h012344, 8'h00, 16'h2211, 1, 0);
		add_entry(OP_RD, 23'h012346, 8'h00, 16'h4433, 1, 0);
		add_entry(OP_WR, 23'h012345, 8'hA5, 16'h0, 0, 1);    // Held into busy
		add_entry(OP_RD, 23'h012344, 8'h00, 16'hA511, 1, 1);
		add_entry(OP_RD, 23'h012346, 8'h00, 16'h4433, 1, 0);
		add_entry(OP_IDLE, 23'd1000, 8'h00, 16'h0, 0, 0);
		for (int g = 0; g < 6; g++) begin
			ra = $random(seed);
			ra[0] = 1'b0;
			d0 = $random(seed);
			d1 = $random(seed);
			add_entry(OP_WR, ra, d0, 16'h0, 0, 0);
			add_entry(OP_WR, ra | 1, d1, 16'h0, 0, 0);
			add_entry(OP_RD, ra, 8'h00, {d1, d0}, 1, 0);    // Read right after write
		end
		for (int i = 0; i < n_ent; i++)
			if (t_op[i] == OP_IDLE)
				idle_total += t_addr[i];
		limit = init_cycles(FREQ) + 40 + 16 * n_ent + refresh_cycles(FREQ) + idle_total;

		repeat (8) @(posedge clk);
		#5 n_reset = 1;
		for (int i = 0; i < n_ent; i++) begin
			while (busy)
				next_slot();    // Power-up or idle refresh
			if (t_op[i] == OP_IDLE) begin
				chk.idle_start();
				repeat (t_addr[i])
					next_slot();
				chk.idle_done(t_addr[i]);
				next_slot();
			end else begin
				address   = t_addr[i];
				wdata     = t_data[i];
				exp_rdata = t_exp[i];
				exp_known = t_known[i];
				wr_n      = (t_op[i] != OP_WR);
				rd_n      = (t_op[i] != OP_RD);
				do
					next_slot();
				while (!busy);
				if (t_hold[i])
					repeat (3) next_slot();
				wr_n = 1;
				rd_n = 1;
			end
		end
		while (busy)
			next_slot();
		repeat (4) @(posedge clk);
		$display("Tests %0d, passed %0d, errors %0d", chk.tests, chk.passes, chk.errors);
		if (chk.errors == 0 && chk.tests == n_ent + 1)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end
endmodule

//--- verilog/ctrl_state_pkg.sv
package ctrl_state_pkg;

	// Sequencer states, WAIT is a NOP countdown with a stored return state
	typedef enum logic [3:0] {
		INIT_WAIT,
		INIT_PRE,
		INIT_REF1,
		INIT_REF2,
		INIT_LMR,
		IDLE,
		ACT,
		COL,
		PRE,
		REFRESH,
		WAIT
	} seq_state_t;

	// --------------------
	// Cycle counts from clock frequency in Hz
	function automatic int clk_period_ns(input int freq);
		return 1_000_000_000 / freq;
	endfunction

	function automatic int init_cycles(input int freq);
		return 120_000 / clk_period_ns(freq);           // 120 us power-up wait
	endfunction

	function automatic int refresh_cycles(input int freq);
		return 15_000 / clk_period_ns(freq);            // 15 us per row refresh
	endfunction

	function automatic int refresh_soon_cycles(input int freq);
		return 10_000 / clk_period_ns(freq);            // Refresh after access past this
	endfunction

endpackage

//--- verilog/sdram_ctrl.sv
`timescale 1ns/1ps

module sdram_ctrl import sdram_proto_pkg::*; #(
	parameter int FREQ = 25_000_000                      // Hz
) (
	input  logic                      clk,
	input  logic                      n_reset,
	// CPU bus
	input  logic                      rd_n,              // Low requests a read
	input  logic                      wr_n,              // Low requests a write
	input  logic [CPU_ADDR_W-1:0]     address,
	input  logic [7:0]                wdata,
	output logic                      busy,
	output logic [SDRAM_DQ_W/2-1:0]   rdata,
	output logic                      rdata_en,
	// SDRAM pins
	output logic                      sdram_clk,
	output logic                      sdram_cke,
	output logic                      sdram_cs_n,
	output logic                      sdram_ras_n,
	output logic                      sdram_cas_n,
	output logic                      sdram_we_n,
	output logic [SDRAM_ADDR_W-1:0]   sdram_addr,
	output logic [SDRAM_BA_W-1:0]     sdram_ba,
	output logic [DQM_W-1:0]          sdram_dqm,
	inout  wire  [SDRAM_DQ_W-1:0]     sdram_dq
);
	logic init_done;
	logic refresh_due;
	logic refresh_soon;
	logic refresh_issued;

	sdram_cmd_if  cmd_bus ();
	sdram_data_if data_bus ();

	sdram_timers #(.FREQ(FREQ)) u_timers (
		.clk, .n_reset, .refresh_issued,
		.init_done, .refresh_due, .refresh_soon
	);

	sdram_sequencer u_sequencer (
		.clk, .n_reset, .rd_n, .wr_n, .address, .wdata, .busy,
		.init_done, .refresh_due, .refresh_soon, .refresh_issued,
		.cmd_bus (cmd_bus.ctrl),
		.data_bus(data_bus.ctrl)
	);

	sdram_datapath u_datapath (
		.clk, .n_reset,
		.data_bus(data_bus.data),
		.rdata, .rdata_en, .sdram_dq
	);

	// --------------------
	// Pins
	assign sdram_clk   = clk;                 // Same edge as the controller
	assign sdram_cke   = 1'b1;
	assign sdram_cs_n  = 1'b0;                // Single device, always selected
	assign sdram_ras_n = cmd_bus.cmd[2];
	assign sdram_cas_n = cmd_bus.cmd[1];
	assign sdram_we_n  = cmd_bus.cmd[0];
	assign sdram_addr  = cmd_bus.addr;
	assign sdram_ba    = cmd_bus.ba;
	assign sdram_dqm   = cmd_bus.dqm;
endmodule

//--- verilog/sdram_datapath.sv
`timescale 1ns/1ps

module sdram_datapath import sdram_proto_pkg::*; (
	input  logic                      clk,
	input  logic                      n_reset,
	sdram_data_if.data                data_bus,
	output logic [SDRAM_DQ_W/2-1:0]   rdata,
	output logic                      rdata_en,
	inout  wire  [SDRAM_DQ_W-1:0]     sdram_dq
);
	logic [SDRAM_DQ_W/2-1:0] rdata_q;
	logic                    rdata_en_q;

	// --------------------
	// Write side
	// Byte copied to every lane, DQM picks the one that lands
	assign sdram_dq = data_bus.drive_en ? {DQM_W{data_bus.wbyte}} : 'z;

	// --------------------
	// Read side
	always_ff @(posedge clk) begin
		if (data_bus.capture) begin
			if (data_bus.half_sel)
				rdata_q <= sdram_dq[SDRAM_DQ_W-1:SDRAM_DQ_W/2];  // Upper half-word
			else
				rdata_q <= sdram_dq[SDRAM_DQ_W/2-1:0];
		end
	end

	// Strobe lines up with the new rdata
	always_ff @(posedge clk) begin
		if (!n_reset)
			rdata_en_q <= 1'b0;
		else
			rdata_en_q <= data_bus.capture;
	end

	assign rdata    = rdata_q;    // Held until the next read
	assign rdata_en = rdata_en_q;
endmodule

//--- verilog/sdram_ifs.sv
`timescale 1ns/1ps

// Command and address lines from sequencer to pins
interface sdram_cmd_if import sdram_proto_pkg::*; ();
	sdram_cmd_t              cmd;     // One clock per command, NOP otherwise
	logic [SDRAM_BA_W-1:0]   ba;
	logic [SDRAM_ADDR_W-1:0] addr;
	logic [DQM_W-1:0]        dqm;     // High masks a byte lane

	modport ctrl (output cmd, ba, addr, dqm);
	modport pins (input cmd, ba, addr, dqm);
endinterface

// Data path control from sequencer
interface sdram_data_if ();
	logic       drive_en;  // High while WRITE is on the pins
	logic [7:0] wbyte;
	logic       capture;   // Read data valid, two cycles after READ
	logic       half_sel;  // 0 low half-word, 1 high half-word

	modport ctrl (output drive_en, wbyte, capture, half_sel);
	modport data (input drive_en, wbyte, capture, half_sel);
endinterface

//--- verilog/sdram_proto_pkg.sv
package sdram_proto_pkg;

	// --------------------
	// Device geometry
	localparam int CPU_ADDR_W    = 23;               // Byte address, 8 MB
	localparam int SDRAM_ADDR_W  = 11;               // Multiplexed row/column bus
	localparam int SDRAM_BA_W    = 2;
	localparam int SDRAM_DQ_W    = 32;
	localparam int DQM_W         = SDRAM_DQ_W / 8;   // One mask bit per byte lane

	// CPU address split
	localparam int BANK_MSB = 22, BANK_LSB = 21;
	localparam int ROW_MSB  = 20, ROW_LSB  = 10;
	localparam int COL_MSB  = 9,  COL_LSB  = 2;
	localparam int COL_W    = COL_MSB - COL_LSB + 1;
	localparam int HALF_BIT = 1;                     // Half-word select for reads
	localparam int LANE_MSB = 1,  LANE_LSB = 0;

	localparam int PRECHARGE_ALL_BIT = 10;           // A10 high closes every bank

	// Write burst single, CAS 2, sequential, burst length 1
	localparam logic [SDRAM_ADDR_W-1:0] MODE_REG_CL2_BL1 = 11'b000_0010_0000;

	// Command is {RAS_n, CAS_n, WE_n}
	typedef enum logic [2:0] {
		LOAD_MODE    = 3'b000,
		AUTO_REFRESH = 3'b001,
		PRECHARGE    = 3'b010,
		ACTIVE       = 3'b011,
		WRITE        = 3'b100,
		READ         = 3'b101,
		NOP          = 3'b111
	} sdram_cmd_t;

endpackage

//--- verilog/sdram_sequencer.sv
`timescale 1ns/1ps

module sdram_sequencer import sdram_proto_pkg::*, ctrl_state_pkg::*; (
	input  logic                  clk,
	input  logic                  n_reset,
	// CPU side
	input  logic                  rd_n,
	input  logic                  wr_n,
	input  logic [CPU_ADDR_W-1:0] address,
	input  logic [7:0]            wdata,
	output logic                  busy,
	// Timers
	input  logic                  init_done,
	input  logic                  refresh_due,
	input  logic                  refresh_soon,
	output logic                  refresh_issued,
	// Towards pins and datapath
	sdram_cmd_if.ctrl             cmd_bus,
	sdram_data_if.ctrl            data_bus
);
	seq_state_t              state, next_state;
	seq_state_t              ret_state, next_ret;   // Where WAIT goes when done
	logic [1:0]              wait_cnt, next_wait;   // WAIT lasts wait_cnt + 1 cycles
	logic                    accept;
	logic                    op_write;              // Current access is a write

	sdram_cmd_t              cmd_q;
	logic [SDRAM_BA_W-1:0]   ba_q;
	logic [SDRAM_ADDR_W-1:0] addr_q;
	logic [DQM_W-1:0]        dqm_q;
	logic [COL_W-1:0]        col_q;
	logic [7:0]              wbyte_q;
	logic                    half_q;
	logic                    drive_en_q;
	logic                    capture_q;
	logic                    busy_q;

	assign accept = (state == IDLE) && (!wr_n || !rd_n);

	// --------------------
	// Next state
	always_comb begin
		next_state = state;
		next_ret   = ret_state;
		next_wait  = wait_cnt;
		case (state)
			INIT_WAIT: if (init_done) next_state = INIT_PRE;
			INIT_PRE: begin
				next_state = WAIT;  // tRP
				next_wait  = 2'd0;
				next_ret   = INIT_REF1;
			end
			INIT_REF1, INIT_REF2: begin
				next_state = WAIT;  // tRC, three NOPs
				next_wait  = 2'd2;
				next_ret   = (state == INIT_REF1) ? INIT_REF2 : INIT_LMR;
			end
			INIT_LMR: begin
				next_state = WAIT;  // tMRD
				next_wait  = 2'd1;
				next_ret   = IDLE;
			end
			IDLE: begin
				if (accept)
					next_state = ACT;        // Write wins over read
				else if (refresh_due)
					next_state = REFRESH;
			end
			ACT: begin
				next_state = WAIT;           // tRCD, two NOPs
				next_wait  = 2'd1;
				next_ret   = COL;
			end
			COL: begin
				if (op_write) begin
					next_state = WAIT;       // Write recovery before precharge
					next_wait  = 2'd0;
					next_ret   = PRE;
				end else begin
					next_state = PRE;        // Read data still lands after this
				end
			end
			PRE: begin
				next_state = WAIT;
				next_wait  = op_write ? 2'd0 : 2'd1;  // Read waits out CAS latency
				next_ret   = refresh_soon ? REFRESH : IDLE;
			end
			REFRESH: begin
				next_state = WAIT;
				next_wait  = 2'd2;
				next_ret   = IDLE;
			end
			WAIT: begin
				if (wait_cnt == 2'd0)
					next_state = ret_state;
				else
					next_wait = wait_cnt - 2'd1;
			end
			default: next_state = IDLE;
		endcase
	end

	// --------------------
	// Registered outputs, all taken from next state
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state      <= INIT_WAIT;
			ret_state  <= IDLE;
			wait_cnt   <= 2'd0;
			cmd_q      <= NOP;
			ba_q       <= '0;
			addr_q     <= '0;
			dqm_q      <= '1;
			drive_en_q <= 1'b0;
			capture_q  <= 1'b0;
			busy_q     <= 1'b1;
			op_write   <= 1'b0;
		end else begin
			state      <= next_state;
			ret_state  <= next_ret;
			wait_cnt   <= next_wait;
			busy_q     <= (next_state != IDLE);
			drive_en_q <= (next_state == COL) && op_write;
			capture_q  <= (state == PRE) && !op_write;   // CAS 2 after READ

			case (next_state)
				INIT_PRE, PRE:               cmd_q <= PRECHARGE;
				INIT_REF1, INIT_REF2, REFRESH: cmd_q <= AUTO_REFRESH;
				INIT_LMR:                    cmd_q <= LOAD_MODE;
				ACT:                         cmd_q <= ACTIVE;
				COL:                         cmd_q <= op_write ? WRITE : READ;
				default:                     cmd_q <= NOP;
			endcase

			case (next_state)
				INIT_PRE, PRE: addr_q <= SDRAM_ADDR_W'(1 << PRECHARGE_ALL_BIT);
				INIT_LMR:      addr_q <= MODE_REG_CL2_BL1;
				ACT:           addr_q <= address[ROW_MSB:ROW_LSB];  // Row straight from CPU
				COL:           addr_q <= SDRAM_ADDR_W'(col_q);      // A10 low, no auto precharge
				default:       addr_q <= addr_q;
			endcase

			if (accept) begin
				op_write <= !wr_n;
				ba_q     <= address[BANK_MSB:BANK_LSB];
				if (!wr_n)
					dqm_q <= ~(DQM_W'(1) << address[LANE_MSB:LANE_LSB]);  // Only target lane
				else
					dqm_q <= '0;
			end
		end
	end

	// Access payload
	always_ff @(posedge clk) begin
		if (accept) begin
			col_q   <= address[COL_MSB:COL_LSB];
			wbyte_q <= wdata;
			half_q  <= address[HALF_BIT];
		end
	end

	assign busy              = busy_q;
	assign refresh_issued    = (cmd_q == AUTO_REFRESH);
	assign cmd_bus.cmd       = cmd_q;
	assign cmd_bus.ba        = ba_q;
	assign cmd_bus.addr      = addr_q;
	assign cmd_bus.dqm       = dqm_q;
	assign data_bus.drive_en = drive_en_q;
	assign data_bus.wbyte    = wbyte_q;
	assign data_bus.capture  = capture_q;
	assign data_bus.half_sel = half_q;
endmodule

//--- verilog/sdram_timers.sv
`timescale 1ns/1ps

module sdram_timers import ctrl_state_pkg::*; #(
	parameter int FREQ = 25_000_000            // Hz
) (
	input  logic clk,
	input  logic n_reset,
	input  logic refresh_issued,               // AUTO_REFRESH on the pins this cycle
	output logic init_done,
	output logic refresh_due,
	output logic refresh_soon
);
	localparam int INIT_CNT = init_cycles(FREQ);
	localparam int INIT_W   = $clog2(INIT_CNT + 1);
	localparam int REF_CNT  = refresh_cycles(FREQ);
	localparam int SOON_CNT = refresh_soon_cycles(FREQ);
	localparam int REF_W    = $clog2(REF_CNT + 1);

	logic [INIT_W-1:0] init_cnt;
	logic [REF_W-1:0]  ref_cnt;

	// Power-up wait, stops at the end
	always_ff @(posedge clk) begin
		if (!n_reset)
			init_cnt <= '0;
		else if (!init_done)
			init_cnt <= init_cnt + 1'b1;
	end

	// Refresh interval, restarts after each refresh
	always_ff @(posedge clk) begin
		if (!n_reset)
			ref_cnt <= '0;
		else if (refresh_issued)
			ref_cnt <= '0;
		else if (!refresh_due)
			ref_cnt <= ref_cnt + 1'b1;    // Saturate at the interval
	end

	assign init_done    = (init_cnt == INIT_W'(INIT_CNT));
	assign refresh_due  = (ref_cnt == REF_W'(REF_CNT));
	assign refresh_soon = (ref_cnt >= REF_W'(SOON_CNT));
endmodule
